// ==== logic/alu_ops_pkg.sv ====
// ALU operations engine shared definitions
// Word widths, operation codes, the configuration word layout and
// the operation function used by the generator and the reference model

package alu_ops_pkg;

    localparam int data_width  = 32;
    localparam int count_width = 16;

    // Defined operation codes, anything above op_max is rejected
    typedef enum logic [3:0] {
        op_pass = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_min  = 4'd6,
        op_max  = 4'd7
    } alu_op_t;

    // Configuration word as carried on the memory response stream
    typedef struct packed {
        alu_op_t     op;
        logic [3:0]  reserved;
        logic [23:0] constant_value;
    } alu_cfg_t;

    // One bus word, configuration on the memory path and raw data on the engine path
    typedef union packed {
        alu_cfg_t                cfg;
        logic [data_width-1:0]   raw;
    } alu_word_t;

    function automatic logic [data_width-1:0] alu_apply(
        input alu_cfg_t              cfg,
        input logic [data_width-1:0] data
    );
        logic [data_width-1:0] operand;
        // Constant is zero-extended, arithmetic wraps
        operand = data_width'(cfg.constant_value);
        case (cfg.op)
            op_pass: alu_apply = data;
            op_add:  alu_apply = data + operand;
            op_sub:  alu_apply = data - operand;
            op_and:  alu_apply = data & operand;
            op_or:   alu_apply = data | operand;
            op_xor:  alu_apply = data ^ operand;
            // Unsigned compares
            op_min:  alu_apply = (data < operand) ? data : operand;
            op_max:  alu_apply = (data > operand) ? data : operand;
            default: alu_apply = data;
        endcase
    endfunction

endpackage

// ==== logic/alu_ops_fifo.sv ====
// Synchronous register FIFO
// Circular buffer with occupancy count, head word shown combinationally,
// prog-full level at a programmable threshold

`timescale 1ns/10ps

module alu_ops_fifo #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 12
) (
    input  logic                                  ap_clk,
    input  logic                                  areset_alu_ops_engine,
    input  logic                                  wr_en,
    input  logic [alu_ops_pkg::data_width-1:0]    wr_data,
    input  logic                                  rd_en,
    output logic [alu_ops_pkg::data_width-1:0]    rd_data,
    output logic                                  empty,
    output logic                                  prog_full,
    output logic [$clog2(fifo_depth+1)-1:0]       level
);

    localparam int ptr_width = $clog2(fifo_depth);
    localparam int lvl_width = $clog2(fifo_depth + 1);

    logic [alu_ops_pkg::data_width-1:0] mem [fifo_depth];
    logic [ptr_width-1:0]               wr_ptr;
    logic [ptr_width-1:0]               rd_ptr;
    logic                               push;
    logic                               pop;

    // Writes into a full buffer are dropped, reads of an empty one ignored
    assign push = wr_en && (level != lvl_width'(fifo_depth));
    assign pop  = rd_en && !empty;

    assign rd_data   = mem[rd_ptr];
    assign empty     = (level == '0);
    assign prog_full = (level >= lvl_width'(prog_thresh));

    // Pointers and occupancy
    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            level <= level + lvl_width'(push) - lvl_width'(pop);
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

// ==== logic/alu_ops_config_memory.sv ====
// Configuration memory
// Decodes memory response words as configurations, drops undefined
// operation codes and queues the rest for the generator

`timescale 1ns/10ps

module alu_ops_config_memory #(
    parameter int fifo_depth  = 16,
    parameter int prog_thresh = 12
) (
    input  logic                    ap_clk,
    input  logic                    areset_alu_ops_engine,
    input  logic                    response_memory_valid,
    input  alu_ops_pkg::alu_word_t  response_memory_data,
    input  logic                    config_setup,
    output alu_ops_pkg::alu_cfg_t   config_word,
    output logic                    config_empty,
    output logic                    response_memory_full
);

    logic                               cfg_accept;
    logic [alu_ops_pkg::data_width-1:0] cfg_head;

    // Only defined codes are stored
    assign cfg_accept = response_memory_valid
                        && (response_memory_data.cfg.op <= alu_ops_pkg::op_max);

    // Head of the queue read back as a configuration
    assign config_word = alu_ops_pkg::alu_cfg_t'(cfg_head);

    alu_ops_fifo #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) cfg_fifo_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .wr_en                 (cfg_accept),
        .wr_data               (response_memory_data.raw),
        .rd_en                 (config_setup),
        .rd_data               (cfg_head),
        .empty                 (config_empty),
        .prog_full             (response_memory_full),
        .level                 ()
    );

endmodule

// ==== logic/alu_ops_generator.sv ====
// ALU operations generator
// Takes one configuration per descriptor, applies it to each engine data
// word through a fixed-depth pipeline and queues results in arrival order

`timescale 1ns/10ps

module alu_ops_generator #(
    parameter int fifo_depth      = 16,
    parameter int prog_thresh     = 12,
    parameter int pipeline_stages = 2
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_alu_ops_engine,
    input  logic                                 descriptor_valid,
    input  logic [alu_ops_pkg::count_width-1:0]  descriptor_count,
    input  alu_ops_pkg::alu_cfg_t                config_word,
    input  logic                                 config_empty,
    output logic                                 config_setup,
    input  logic                                 response_engine_valid,
    input  logic [alu_ops_pkg::data_width-1:0]   response_engine_data,
    output logic                                 response_engine_full,
    input  logic                                 request_engine_ready,
    output logic                                 request_engine_valid,
    output logic [alu_ops_pkg::data_width-1:0]   request_engine_data,
    output logic                                 fifos_empty,
    output logic                                 done
);

    localparam int lvl_width = $clog2(fifo_depth + 1);

    // FSM encodings
    localparam logic [1:0] st_idle     = 2'd0;
    localparam logic [1:0] st_wait_cfg = 2'd1;
    localparam logic [1:0] st_run      = 2'd2;

    logic [1:0]                          state;
    alu_ops_pkg::alu_cfg_t               cfg_reg;
    logic [alu_ops_pkg::count_width-1:0] job_count;
    logic [alu_ops_pkg::count_width-1:0] issued_count;
    logic [alu_ops_pkg::count_width-1:0] sent_count;

    logic                                data_empty;
    logic [alu_ops_pkg::data_width-1:0]  data_head;
    logic                                res_empty;
    logic [lvl_width-1:0]                res_level;
    logic                                issue;

    logic [pipeline_stages-1:0]          pipe_valid;
    logic [alu_ops_pkg::data_width-1:0]  pipe_data [pipeline_stages];
    logic [lvl_width-1:0]                pipe_count;

    // ----------------------------------------------------------------------
    // Control
    // ----------------------------------------------------------------------

    // Pop the configuration as soon as one is waiting
    assign config_setup = (state == st_wait_cfg) && !config_empty;

    // Issue only while results in flight plus queued still fit the result FIFO
    assign issue = (state == st_run) && !data_empty && (issued_count != job_count)
                   && ((int'(pipe_count) + int'(res_level)) < fifo_depth);

    // Downstream ready drains the result FIFO directly
    assign request_engine_valid = request_engine_ready && !res_empty;
    assign fifos_empty          = data_empty && res_empty;

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            state        <= st_idle;
            job_count    <= '0;
            issued_count <= '0;
            sent_count   <= '0;
            done         <= 1'b0;
        end else begin
            if (issue) begin
                issued_count <= issued_count + 1'b1;
            end
            if (request_engine_valid) begin
                sent_count <= sent_count + 1'b1;
            end
            case (state)
                st_idle: begin
                    // Descriptors outside idle are ignored
                    if (descriptor_valid) begin
                        job_count    <= descriptor_count;
                        issued_count <= '0;
                        sent_count   <= '0;
                        done         <= 1'b0;
                        state        <= st_wait_cfg;
                    end
                end
                st_wait_cfg: begin
                    if (config_setup) begin
                        state <= st_run;
                    end
                end
                st_run: begin
                    // Job ends when every result has left
                    if (sent_count == job_count) begin
                        done  <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Configuration latched with the pop
    always_ff @(posedge ap_clk) begin
        if (config_setup) begin
            cfg_reg <= config_word;
        end
    end

    // ----------------------------------------------------------------------
    // Operation pipeline
    // ----------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_alu_ops_engine) begin
            pipe_valid <= '0;
            pipe_count <= '0;
        end else begin
            pipe_valid[0] <= issue;
            for (int i = 1; i < pipeline_stages; i++) begin
                pipe_valid[i] <= pipe_valid[i-1];
            end
            // Items enter on issue and leave into the result FIFO
            pipe_count <= pipe_count + lvl_width'(issue)
                          - lvl_width'(pipe_valid[pipeline_stages-1]);
        end
    end

    always_ff @(posedge ap_clk) begin
        // Compute in the first stage, then carry the result along
        pipe_data[0] <= alu_ops_pkg::alu_apply(cfg_reg, data_head);
        for (int i = 1; i < pipeline_stages; i++) begin
            pipe_data[i] <= pipe_data[i-1];
        end
    end

    // ----------------------------------------------------------------------
    // Data and result buffers
    // ----------------------------------------------------------------------

    alu_ops_fifo #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) data_fifo_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .wr_en                 (response_engine_valid),
        .wr_data               (response_engine_data),
        .rd_en                 (issue),
        .rd_data               (data_head),
        .empty                 (data_empty),
        .prog_full             (response_engine_full),
        .level                 ()
    );

    alu_ops_fifo #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) result_fifo_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .wr_en                 (pipe_valid[pipeline_stages-1]),
        .wr_data               (pipe_data[pipeline_stages-1]),
        .rd_en                 (request_engine_valid),
        .rd_data               (request_engine_data),
        .empty                 (res_empty),
        .prog_full             (),
        .level                 (res_level)
    );

endmodule

// ==== logic/alu_ops_engine.sv ====
// ALU operations engine top level
// Registers reset per child, registers every input and the request
// output, and qualifies the generator's done with all buffers empty

`timescale 1ns/10ps

module alu_ops_engine #(
    parameter int fifo_depth      = 16,
    parameter int prog_thresh     = 12,
    parameter int pipeline_stages = 2
) (
    input  logic                                 ap_clk,
    input  logic                                 areset_alu_ops_engine,
    input  logic                                 descriptor_valid,
    input  logic [alu_ops_pkg::count_width-1:0]  descriptor_count,
    input  logic                                 response_memory_valid,
    input  alu_ops_pkg::alu_word_t               response_memory_data,
    output logic                                 response_memory_full,
    input  logic                                 response_engine_valid,
    input  logic [alu_ops_pkg::data_width-1:0]   response_engine_data,
    output logic                                 response_engine_full,
    input  logic                                 request_engine_ready,
    output logic                                 request_engine_valid,
    output logic [alu_ops_pkg::data_width-1:0]   request_engine_data,
    output logic                                 done
);

    logic areset_top;
    logic areset_config;
    logic areset_generator;

    logic                                descriptor_valid_reg;
    logic [alu_ops_pkg::count_width-1:0] descriptor_count_reg;
    logic                                response_memory_valid_reg;
    alu_ops_pkg::alu_word_t              response_memory_data_reg;
    logic                                response_engine_valid_reg;
    logic [alu_ops_pkg::data_width-1:0]  response_engine_data_reg;
    logic                                request_engine_ready_reg;

    alu_ops_pkg::alu_cfg_t               config_word;
    logic                                config_empty;
    logic                                config_setup;
    logic                                memory_full_int;
    logic                                engine_full_int;
    logic                                request_valid_int;
    logic [alu_ops_pkg::data_width-1:0]  request_data_int;
    logic                                generator_fifos_empty;
    logic                                generator_done;
    logic                                fifos_empty_reg;

    // ----------------------------------------------------------------------
    // Reset and input registers
    // ----------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        areset_top       <= areset_alu_ops_engine;
        areset_config    <= areset_alu_ops_engine;
        areset_generator <= areset_alu_ops_engine;
    end

    // Strobes and ready level
    always_ff @(posedge ap_clk) begin
        if (areset_top) begin
            descriptor_valid_reg      <= 1'b0;
            response_memory_valid_reg <= 1'b0;
            response_engine_valid_reg <= 1'b0;
            request_engine_ready_reg  <= 1'b0;
        end else begin
            descriptor_valid_reg      <= descriptor_valid;
            response_memory_valid_reg <= response_memory_valid;
            response_engine_valid_reg <= response_engine_valid;
            request_engine_ready_reg  <= request_engine_ready;
        end
    end

    // Payloads
    always_ff @(posedge ap_clk) begin
        descriptor_count_reg     <= descriptor_count;
        response_memory_data_reg <= response_memory_data;
        response_engine_data_reg <= response_engine_data;
    end

    // ----------------------------------------------------------------------
    // Output registers and done
    // ----------------------------------------------------------------------

    always_ff @(posedge ap_clk) begin
        if (areset_top) begin
            request_engine_valid <= 1'b0;
            response_memory_full <= 1'b0;
            response_engine_full <= 1'b0;
            fifos_empty_reg      <= 1'b1;
            done                 <= 1'b0;
        end else begin
            request_engine_valid <= request_valid_int;
            response_memory_full <= memory_full_int;
            response_engine_full <= engine_full_int;
            // Every buffer in the engine drained
            fifos_empty_reg      <= config_empty & generator_fifos_empty;
            done                 <= generator_done & fifos_empty_reg;
        end
    end

    always_ff @(posedge ap_clk) begin
        request_engine_data <= request_data_int;
    end

    // ----------------------------------------------------------------------
    // Children
    // ----------------------------------------------------------------------

    alu_ops_config_memory #(
        .fifo_depth  (fifo_depth),
        .prog_thresh (prog_thresh)
    ) config_memory_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_config),
        .response_memory_valid (response_memory_valid_reg),
        .response_memory_data  (response_memory_data_reg),
        .config_setup          (config_setup),
        .config_word           (config_word),
        .config_empty          (config_empty),
        .response_memory_full  (memory_full_int)
    );

    alu_ops_generator #(
        .fifo_depth      (fifo_depth),
        .prog_thresh     (prog_thresh),
        .pipeline_stages (pipeline_stages)
    ) generator_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_generator),
        .descriptor_valid      (descriptor_valid_reg),
        .descriptor_count      (descriptor_count_reg),
        .config_word           (config_word),
        .config_empty          (config_empty),
        .config_setup          (config_setup),
        .response_engine_valid (response_engine_valid_reg),
        .response_engine_data  (response_engine_data_reg),
        .response_engine_full  (engine_full_int),
        .request_engine_ready  (request_engine_ready_reg),
        .request_engine_valid  (request_valid_int),
        .request_engine_data   (request_data_int),
        .fifos_empty           (generator_fifos_empty),
        .done                  (generator_done)
    );

endmodule

// ==== verif/alu_ops_engine_tb.sv ====
// Testbench for the ALU operations engine
// Replays jobs from a vector file, drives the memory and engine response
// streams on the falling edge and checks every result in arrival order
// while downstream ready toggles at random

`timescale 1ns/10ps

module alu_ops_engine_tb;

    localparam int fifo_depth      = 16;
    localparam int prog_thresh     = 12;
    localparam int pipeline_stages = 2;
    localparam int clk_half        = 20;
    // Cycles a late configuration word trails its descriptor
    localparam int late_cfg_delay  = 12;

    logic                                ap_clk = 1'b0;
    logic                                areset_alu_ops_engine;
    logic                                descriptor_valid;
    logic [alu_ops_pkg::count_width-1:0] descriptor_count;
    logic                                response_memory_valid;
    alu_ops_pkg::alu_word_t              response_memory_data;
    logic                                response_memory_full;
    logic                                response_engine_valid;
    logic [alu_ops_pkg::data_width-1:0]  response_engine_data;
    logic                                response_engine_full;
    logic                                request_engine_ready = 1'b0;
    logic                                request_engine_valid;
    logic [alu_ops_pkg::data_width-1:0]  request_engine_data;
    logic                                done;

    // Jobs as read from the vector file
    logic [31:0] job_mode[$];
    logic [31:0] job_junk[$];
    logic [31:0] job_cfg[$];
    logic [31:0] job_count[$];
    int          job_base[$];
    logic [31:0] data_words[$];
    logic [31:0] result_words[$];

    // Scoreboard state
    logic [31:0] expected_q[$];
    int          received     = 0;
    int          job_target   = 0;
    bit          job_active   = 1'b0;
    bit          cfg_released = 1'b1;
    string       test_name    = "reset";
    integer      seed         = 34;
    integer      fd;

    always #clk_half ap_clk = ~ap_clk;

    alu_ops_engine #(
        .fifo_depth      (fifo_depth),
        .prog_thresh     (prog_thresh),
        .pipeline_stages (pipeline_stages)
    ) dut_i (
        .ap_clk                (ap_clk),
        .areset_alu_ops_engine (areset_alu_ops_engine),
        .descriptor_valid      (descriptor_valid),
        .descriptor_count      (descriptor_count),
        .response_memory_valid (response_memory_valid),
        .response_memory_data  (response_memory_data),
        .response_memory_full  (response_memory_full),
        .response_engine_valid (response_engine_valid),
        .response_engine_data  (response_engine_data),
        .response_engine_full  (response_engine_full),
        .request_engine_ready  (request_engine_ready),
        .request_engine_valid  (request_engine_valid),
        .request_engine_data   (request_engine_data),
        .done                  (done)
    );

    // ------------------------------------------------------------------
    // Failure reporting and compare
    // ------------------------------------------------------------------

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            stop_with_failure($sformatf("Fail %s: expected %08h, actual %08h",
                                        name, expected, actual));
        end
    endtask

    // ------------------------------------------------------------------
    // Vector file
    // ------------------------------------------------------------------

    // Next hex field with comment lines skipped up to their newline
    task automatic read_field(output logic [31:0] value, output bit found);
        string tok;
        int    c;
        found = 1'b0;
        value = '0;
        while (!found && $fscanf(fd, "%s", tok) == 1) begin
            if (tok.getc(0) == "#") begin
                c = $fgetc(fd);
                while (c != "\n" && c != -1) begin
                    c = $fgetc(fd);
                end
            end else begin
                value = tok.atohex();
                found = 1'b1;
            end
        end
    endtask

    task automatic load_vectors();
        logic [31:0] fields[$];
        logic [31:0] value;
        bit          found;
        int          idx;
        int          count;
        fd = $fopen("verif/alu_ops_vectors.txt", "r");
        if (fd == 0) begin
            stop_with_failure("Vector file verif/alu_ops_vectors.txt could not be opened");
        end
        read_field(value, found);
        while (found) begin
            fields.push_back(value);
            read_field(value, found);
        end
        $fclose(fd);
        idx = 0;
        while (idx < fields.size()) begin
            count = (idx + 3 < fields.size()) ? int'(fields[idx+3]) : 0;
            if (idx + 4 + 2 * count > fields.size()) begin
                stop_with_failure("Vector file ends in the middle of a job");
            end
            job_mode.push_back(fields[idx]);
            job_junk.push_back(fields[idx+1]);
            job_cfg.push_back(fields[idx+2]);
            job_count.push_back(fields[idx+3]);
            job_base.push_back(data_words.size());
            for (int k = 0; k < count; k++) begin
                data_words.push_back(fields[idx+4+2*k]);
                result_words.push_back(fields[idx+5+2*k]);
                // File expectation against the operation rule
                check_value($sformatf("vector job %0d word %0d", job_cfg.size() - 1, k),
                            fields[idx+5+2*k],
                            alu_ops_pkg::alu_apply(alu_ops_pkg::alu_cfg_t'(fields[idx+2]),
                                                   fields[idx+4+2*k]));
            end
            idx += 4 + 2 * count;
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------

    task automatic send_config(input logic [31:0] word);
        @(negedge ap_clk);
        while (response_memory_full) begin
            @(negedge ap_clk);
        end
        response_memory_valid    = 1'b1;
        response_memory_data.raw = word;
        @(negedge ap_clk);
        response_memory_valid = 1'b0;
    endtask

    // Descriptor pulse after which done of the previous job has to drop
    task automatic start_descriptor(input int count);
        int n;
        @(negedge ap_clk);
        descriptor_valid = 1'b1;
        descriptor_count = 16'(count);
        @(negedge ap_clk);
        descriptor_valid = 1'b0;
        n = 0;
        while (done && n < 8) begin
            @(negedge ap_clk);
            n++;
        end
        if (done) begin
            stop_with_failure($sformatf("%s: done stayed high after the descriptor", test_name));
        end else begin
            job_active = 1'b1;
        end
    endtask

    // One word per cycle with a pause while the data FIFO reports full
    task automatic send_data(input int base, input int count);
        int k;
        k = 0;
        while (k < count) begin
            @(negedge ap_clk);
            if (response_engine_full) begin
                response_engine_valid = 1'b0;
            end else begin
                response_engine_valid = 1'b1;
                response_engine_data  = data_words[base+k];
                k++;
            end
        end
        @(negedge ap_clk);
        response_engine_valid = 1'b0;
    endtask

    task automatic run_job(input int j);
        int          count;
        int          base;
        logic [31:0] mode;
        logic [31:0] cfg;
        count      = int'(job_count[j]);
        base       = job_base[j];
        mode       = job_mode[j];
        cfg        = job_cfg[j];
        test_name  = $sformatf("job %0d op %0d", j, cfg[31:28]);
        job_target = received + count;
        for (int k = 0; k < count; k++) begin
            expected_q.push_back(result_words[base+k]);
        end
        // A late job may show no result before its configuration is sent
        cfg_released = (mode != 32'd1);
        if (mode == 32'd2) begin
            send_config(job_junk[j]);
        end
        if (mode != 32'd1) begin
            send_config(cfg);
        end
        fork
            begin
                start_descriptor(count);
                send_data(base, count);
            end
            begin
                if (mode == 32'd1) begin
                    repeat (late_cfg_delay) @(negedge ap_clk);
                    cfg_released = 1'b1;
                    send_config(cfg);
                end
            end
        join
        while (received != job_target) begin
            @(negedge ap_clk);
        end
        while (!done) begin
            @(negedge ap_clk);
        end
        job_active = 1'b0;
    endtask

    // ------------------------------------------------------------------
    // Ready, scoreboard and watchdog
    // ------------------------------------------------------------------

    // Ready high about three cycles in four
    always @(negedge ap_clk) begin
        request_engine_ready = (($random(seed) & 3) != 0);
    end

    always @(negedge ap_clk) begin
        if (!areset_alu_ops_engine && request_engine_valid === 1'b1) begin
            if (!cfg_released) begin
                stop_with_failure($sformatf("%s: a result came before its configuration word",
                                            test_name));
            end else if (expected_q.size() == 0) begin
                stop_with_failure($sformatf("%s: a result came with none outstanding",
                                            test_name));
            end else begin
                check_value($sformatf("%s word %0d", test_name, received),
                            expected_q.pop_front(), request_engine_data);
                received++;
            end
        end
        // Done only after the last result of the job
        if (job_active && done && received != job_target) begin
            stop_with_failure($sformatf("%s: done rose before the last result", test_name));
        end
    end

    initial begin : watchdog
        int limit;
        @(posedge ap_clk);
        limit = data_words.size() * 40 + 200;
        repeat (limit) @(posedge ap_clk);
        stop_with_failure("Timeout, results stopped arriving from the engine");
    end

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        areset_alu_ops_engine = 1'b1;
        descriptor_valid      = 1'b0;
        descriptor_count      = '0;
        response_memory_valid = 1'b0;
        response_memory_data  = '0;
        response_engine_valid = 1'b0;
        response_engine_data  = '0;
        load_vectors();
        repeat (4) @(negedge ap_clk);
        areset_alu_ops_engine = 1'b0;
        // Outputs idle out of reset
        repeat (2) @(negedge ap_clk);
        check_value("reset request_engine_valid", 32'd0, 32'(request_engine_valid));
        check_value("reset done", 32'd0, 32'(done));
        check_value("reset response_memory_full", 32'd0, 32'(response_memory_full));
        check_value("reset response_engine_full", 32'd0, 32'(response_engine_full));
        for (int j = 0; j < job_cfg.size(); j++) begin
            run_job(j);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== list.f ====
logic/alu_ops_pkg.sv
logic/alu_ops_fifo.sv
logic/alu_ops_config_memory.sv
logic/alu_ops_generator.sv
logic/alu_ops_engine.sv
verif/alu_ops_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the ALU operations engine testbench with Verilator, runs it and
# looks for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module alu_ops_engine_tb \
    -f list.f -o alu_ops_sim \
    && ./obj_dir/alu_ops_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "All checks passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verif/alu_ops_vectors.txt ====
# mode junk config count, then data and expected result pairs, all hex
# mode 0 sends config first, 1 sends it after the descriptor, 2 sends junk before it
0 00000000 00123456 3 00000001 00000001 deadbeef deadbeef ffffffff ffffffff
0 00000000 10000010 3 00000005 00000015 fffffff8 00000008 12345678 12345688
0 00000000 20000100 3 00001000 00000f00 00000050 ffffff50 80000000 7fffff00
0 00000000 30ff00ff 3 12345678 00340078 ffffffff 00ff00ff 0f0f0f0f 000f000f
0 00000000 40a0a0a0 3 01010101 01a1a1a1 00000000 00a0a0a0 ff00000f ffa0a0af
0 00000000 50ffffff 3 00000000 00ffffff 12345678 12cba987 ffffffff ff000000
0 00000000 60001000 4 00000fff 00000fff 00002000 00001000 80000000 00001000 00001000 00001000
0 00000000 70800000 3 007fffff 00800000 90000000 90000000 00800001 00800001
1 00000000 1a000001 3 00000000 00000001 0000ffff 00010000 ffffffff 00000000
2 8000ffff 20000001 3 00000001 00000000 00000000 ffffffff 00000100 000000ff
2 c0abcdef 50000f0f 3 0000ffff 0000f0f0 12340000 12340f0f 00000f0f 00000000
0 00000000 6000000a 4 00000005 00000005 0000000a 0000000a 0000000b 0000000a ffffffff 0000000a
1 00000000 7000ffff 3 00010000 00010000 00000001 0000ffff 0000fffe 0000ffff
2 ffffffff 0f000000 3 a5a5a5a5 a5a5a5a5 5a5a5a5a 5a5a5a5a 00000000 00000000
1 00000000 30000ff0 3 ffffffff 00000ff0 12345678 00000670 0000000f 00000000
0 00000000 40000001 3 fffffffe ffffffff 00000001 00000001 80000000 80000001
0 00000000 20ffffff 3 00000000 ff000001 01000000 00000001 ffffffff ff000000
2 9000abcd 10ffffff 3 ff000001 00000000 00000001 01000000 12345678 13345677
